/* oflow_pkg.sv */
// --------------------
// oflow feature-extraction core
// shared widths, address map, bus and box types, FSM states
// --------------------
package oflow_pkg;

	// --------------------
	// sizes
	// --------------------
	// processing elements, also the set size
	localparam int PE_NUM = 4;
	// log2 of the set size, position inside a set
	localparam int PE_IDX_W = 2;
	// box memory depth
	localparam int MAX_BBOX = 32;
	localparam int BBOX_IDX_W = 5;
	// box count register, 0 to 32
	localparam int NUM_BBOX_W = 6;
	localparam int SET_W = 4;
	localparam int BOX_FIELD_W = 8;
	// w*h of two 8 bit fields
	localparam int FEAT_W = 16;
	// 32 features of 16 bits
	localparam int SUM_W = 21;
	// shift-add steps, one per multiplier bit
	localparam int MUL_STEPS = 8;
	localparam int MUL_CNT_W = 3;

	// --------------------
	// wishbone address map
	// --------------------
	localparam int ADR_W = 8;
	localparam int DAT_W = 32;
	localparam logic [ADR_W-1:0] ADR_CTRL = 8'h00;
	localparam logic [ADR_W-1:0] ADR_STATUS = 8'h01;
	localparam logic [ADR_W-1:0] ADR_NUM_BBOX = 8'h02;
	localparam logic [ADR_W-1:0] ADR_FRAME_SUM = 8'h03;
	localparam logic [ADR_W-1:0] ADR_BBOX_BASE = 8'h40;
	localparam logic [ADR_W-1:0] ADR_RES_BASE = 8'h80;

	// one box per 32 bit word, h in the low byte
	typedef struct packed {
		logic [BOX_FIELD_W-1:0] x;
		logic [BOX_FIELD_W-1:0] y;
		logic [BOX_FIELD_W-1:0] w;
		logic [BOX_FIELD_W-1:0] h;
	} bbox_t;

	// host side of the bus
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [ADR_W-1:0] adr;
		logic [DAT_W-1:0] dat;
	} wb_req_t;

	// slave side of the bus
	typedef struct packed {
		logic ack;
		logic [DAT_W-1:0] dat;
	} wb_rsp_t;

	typedef enum logic [1:0] {FE_IDLE, FE_START, FE_WAIT, FE_REG} fe_state_t;
	typedef enum logic {PE_IDLE, PE_MUL} pe_state_t;
	typedef enum logic {RG_IDLE, RG_WRITE} reg_state_t;

endpackage

/* oflow_wb_regs.sv */
// --------------------
// wishbone classic register block
// control/status, box memory and result memory
// --------------------
`timescale 1ns/1ps

module oflow_wb_regs import oflow_pkg::*; (
	input  logic clk,
	input  logic reset_N,
	input  wb_req_t wb_req,
	output wb_rsp_t wb_rsp,
	output logic frame_start,
	output logic [NUM_BBOX_W-1:0] num_bbox,
	input  logic [SET_W-1:0] set_idx,
	output bbox_t [PE_NUM-1:0] set_bbox,
	input  logic busy,
	input  logic frame_done,
	input  logic res_we,
	input  logic [BBOX_IDX_W-1:0] res_idx,
	input  logic [FEAT_W-1:0] res_data,
	input  logic [SUM_W-1:0] frame_sum
);

	bbox_t box_mem [MAX_BBOX];
	logic [FEAT_W-1:0] res_mem [MAX_BBOX];
	logic access;
	logic wr_en;
	logic is_box;
	logic is_res;
	logic [BBOX_IDX_W-1:0] box_adr_idx;
	logic [BBOX_IDX_W-1:0] res_adr_idx;
	logic [DAT_W-1:0] rd_data;
	logic [DAT_W-1:0] rd_data_q;
	logic ack_q;
	logic done_q;

	// --------------------
	// decode
	// --------------------
	// new access only while no ack is out, gives one ack per strobe
	assign access = wb_req.cyc && wb_req.stb && !ack_q;
	assign wr_en = access && wb_req.we;
	assign is_box = (wb_req.adr >= ADR_BBOX_BASE)
		&& (wb_req.adr < ADR_BBOX_BASE + ADR_W'(MAX_BBOX));
	assign is_res = (wb_req.adr >= ADR_RES_BASE)
		&& (wb_req.adr < ADR_RES_BASE + ADR_W'(MAX_BBOX));
	assign box_adr_idx = BBOX_IDX_W'(wb_req.adr - ADR_BBOX_BASE);
	assign res_adr_idx = BBOX_IDX_W'(wb_req.adr - ADR_RES_BASE);

	// read mux, unmapped reads give zero
	always_comb begin
		rd_data = '0;
		if (is_box) begin
			rd_data = box_mem[box_adr_idx];
		end else if (is_res) begin
			rd_data = DAT_W'(res_mem[res_adr_idx]);
		end else begin
			case (wb_req.adr)
				ADR_STATUS: rd_data = DAT_W'({done_q, busy});
				ADR_NUM_BBOX: rd_data = DAT_W'(num_bbox);
				ADR_FRAME_SUM: rd_data = DAT_W'(frame_sum);
				default: rd_data = '0;
			endcase
		end
	end

	// --------------------
	// control registers
	// --------------------
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			ack_q <= 1'b0;
			frame_start <= 1'b0;
			num_bbox <= '0;
			done_q <= 1'b0;
		end else begin
			ack_q <= access;
			// start only from idle, dropped while busy
			frame_start <= wr_en && (wb_req.adr == ADR_CTRL) && wb_req.dat[0] && !busy;
			// count clamped to memory depth
			if (wr_en && (wb_req.adr == ADR_NUM_BBOX)) begin
				if (wb_req.dat > DAT_W'(MAX_BBOX))
					num_bbox <= NUM_BBOX_W'(MAX_BBOX);
				else
					num_bbox <= wb_req.dat[NUM_BBOX_W-1:0];
			end
			// done lives from frame end to next start
			if (frame_start)
				done_q <= 1'b0;
			else if (frame_done)
				done_q <= 1'b1;
		end
	end

	// read data captured with the ack
	always_ff @(posedge clk) begin
		if (access)
			rd_data_q <= rd_data;
	end

	// --------------------
	// memories
	// --------------------
	always_ff @(posedge clk) begin
		if (wr_en && is_box)
			box_mem[box_adr_idx] <= wb_req.dat;
	end

	// result side written only by registration
	always_ff @(posedge clk) begin
		if (res_we)
			res_mem[res_idx] <= res_data;
	end

	// four boxes of the current set, no latency
	always_comb begin
		for (int i = 0; i < PE_NUM; i++) begin
			set_bbox[i] = box_mem[BBOX_IDX_W'(set_idx * PE_NUM + i)];
		end
	end

	assign wb_rsp.ack = ack_q;
	assign wb_rsp.dat = rd_data_q;

endmodule

/* oflow_fe_ctrl.sv */
// --------------------
// set-control FSM
// starts PEs one set at a time, waits for registration
// --------------------
`timescale 1ns/1ps

module oflow_fe_ctrl import oflow_pkg::*; (
	input  logic clk,
	input  logic reset_N,
	input  logic frame_start,
	input  logic [NUM_BBOX_W-1:0] num_bbox,
	output logic [SET_W-1:0] set_idx,
	output logic [PE_NUM-1:0] start_fe,
	input  logic [PE_NUM-1:0] done_fe,
	output logic set_done,
	output logic [PE_NUM-1:0] active_mask,
	input  logic done_registration,
	output logic busy,
	output logic frame_done
);

	fe_state_t state;
	fe_state_t next_state;
	logic [NUM_BBOX_W-1:0] nb_q;
	logic [NUM_BBOX_W:0] nb_round;
	logic [SET_W-1:0] num_sets;
	logic [SET_W-1:0] set_cnt;
	logic [NUM_BBOX_W-1:0] remain;
	logic [PE_IDX_W:0] act_cnt;
	logic last_set;
	logic all_done;

	// --------------------
	// set bookkeeping
	// --------------------
	// sets = ceil(count / set size)
	assign nb_round = {1'b0, nb_q} + (NUM_BBOX_W+1)'(PE_NUM - 1);
	assign num_sets = SET_W'(nb_round >> PE_IDX_W);
	assign last_set = (set_cnt == num_sets - 1'b1);

	// boxes not yet handled, from the current set on
	assign remain = nb_q - NUM_BBOX_W'({set_cnt, {PE_IDX_W{1'b0}}});
	// full set unless fewer boxes are left
	assign act_cnt = (remain >= NUM_BBOX_W'(PE_NUM)) ? (PE_IDX_W+1)'(PE_NUM)
		: remain[PE_IDX_W:0];
	// low act_cnt bits set
	assign active_mask = ~({PE_NUM{1'b1}} << act_cnt);

	// idle PEs may still hold an old done, mask them out
	assign all_done = ((done_fe & active_mask) == active_mask);

	assign set_idx = set_cnt;
	assign busy = (state != FE_IDLE);
	// one-cycle pulse, FE_START lasts a single cycle
	assign start_fe = (state == FE_START) ? active_mask : '0;

	// --------------------
	// next state
	// --------------------
	always_comb begin
		next_state = state;
		case (state)
			FE_IDLE: begin
				// empty frame never leaves idle
				if (frame_start && (num_bbox != '0))
					next_state = FE_START;
			end
			FE_START: begin
				next_state = FE_WAIT;
			end
			FE_WAIT: begin
				if (all_done)
					next_state = FE_REG;
			end
			FE_REG: begin
				if (done_registration)
					next_state = last_set ? FE_IDLE : FE_START;
			end
			default: next_state = FE_IDLE;
		endcase
	end

	// --------------------
	// state and counters
	// --------------------
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			state <= FE_IDLE;
			nb_q <= '0;
			set_cnt <= '0;
			set_done <= 1'b0;
			frame_done <= 1'b0;
		end else begin
			state <= next_state;
			set_done <= 1'b0;
			frame_done <= 1'b0;
			case (state)
				FE_IDLE: begin
					if (frame_start) begin
						nb_q <= num_bbox;
						set_cnt <= '0;
						// zero count ends right away
						if (num_bbox == '0)
							frame_done <= 1'b1;
					end
				end
				FE_WAIT: begin
					// hand the set over to registration
					if (all_done)
						set_done <= 1'b1;
				end
				FE_REG: begin
					if (done_registration) begin
						if (last_set)
							frame_done <= 1'b1;
						else
							set_cnt <= set_cnt + 1'b1;
					end
				end
				default: ;
			endcase
		end
	end

endmodule

/* oflow_fe_pe.sv */
// --------------------
// processing element
// box area w*h by 8 step shift-add
// --------------------
`timescale 1ns/1ps

module oflow_fe_pe import oflow_pkg::*; (
	input  logic clk,
	input  logic reset_N,
	input  logic start,
	input  bbox_t box,
	output logic done,
	output logic [FEAT_W-1:0] feature
);

	pe_state_t state;
	logic [MUL_CNT_W-1:0] step;
	logic [FEAT_W-1:0] mcand;
	logic [BOX_FIELD_W-1:0] mplier;
	logic [FEAT_W-1:0] acc;

	// --------------------
	// control
	// --------------------
	// step 0 runs on the start edge, so done lands 8 cycles after start
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			state <= PE_IDLE;
			step <= '0;
			done <= 1'b0;
		end else if (start) begin
			state <= PE_MUL;
			step <= MUL_CNT_W'(1);
			done <= 1'b0;
		end else if (state == PE_MUL) begin
			step <= step + 1'b1;
			// last multiplier bit
			if (step == MUL_CNT_W'(MUL_STEPS - 1)) begin
				state <= PE_IDLE;
				done <= 1'b1;
			end
		end
	end

	// --------------------
	// datapath
	// --------------------
	always_ff @(posedge clk) begin
		if (start) begin
			// first partial product taken here
			acc <= box.h[0] ? FEAT_W'(box.w) : '0;
			mcand <= FEAT_W'(box.w) << 1;
			mplier <= box.h >> 1;
		end else if (state == PE_MUL) begin
			if (mplier[0])
				acc <= acc + mcand;
			mcand <= mcand << 1;
			mplier <= mplier >> 1;
		end
	end

	// held until the next start
	assign feature = acc;

endmodule

/* oflow_registration.sv */
// --------------------
// feature registration
// writes a set into result memory, keeps the frame sum
// --------------------
`timescale 1ns/1ps

module oflow_registration import oflow_pkg::*; (
	input  logic clk,
	input  logic reset_N,
	input  logic frame_start,
	input  logic set_done,
	input  logic [PE_NUM-1:0] active_mask,
	input  logic [SET_W-1:0] set_idx,
	input  logic [PE_NUM-1:0][FEAT_W-1:0] features,
	output logic res_we,
	output logic [BBOX_IDX_W-1:0] res_idx,
	output logic [FEAT_W-1:0] res_data,
	output logic [SUM_W-1:0] frame_sum,
	output logic done_registration
);

	reg_state_t state;
	// remaining elements, bit 0 is the one being written
	logic [PE_NUM-1:0] mask_q;
	logic [PE_IDX_W-1:0] pos;

	// --------------------
	// sequencing
	// --------------------
	// one write per active element, done one cycle after the last
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			state <= RG_IDLE;
			mask_q <= '0;
			pos <= '0;
			frame_sum <= '0;
			done_registration <= 1'b0;
		end else begin
			done_registration <= 1'b0;
			if (frame_start) begin
				// new frame, sum restarts
				frame_sum <= '0;
			end else begin
				case (state)
					RG_IDLE: begin
						if (set_done) begin
							mask_q <= active_mask;
							pos <= '0;
							state <= RG_WRITE;
						end
					end
					RG_WRITE: begin
						frame_sum <= frame_sum + SUM_W'(features[pos]);
						pos <= pos + 1'b1;
						mask_q <= mask_q >> 1;
						// mask is contiguous, a clear next bit ends the set
						if (!mask_q[1]) begin
							state <= RG_IDLE;
							done_registration <= 1'b1;
						end
					end
					default: state <= RG_IDLE;
				endcase
			end
		end
	end

	// --------------------
	// result write port
	// --------------------
	assign res_we = (state == RG_WRITE) && mask_q[0];
	// set base plus position in the set
	assign res_idx = BBOX_IDX_W'({set_idx, pos});
	assign res_data = features[pos];

endmodule

/* oflow_core_top.sv */
// --------------------
// oflow core top level
// register block, set FSM, four PEs, registration
// --------------------
`timescale 1ns/1ps

module oflow_core_top import oflow_pkg::*; (
	input  logic clk,
	input  logic reset_N,
	input  wb_req_t wb_req,
	output wb_rsp_t wb_rsp
);

	logic frame_start;
	logic frame_done;
	logic busy;
	logic [NUM_BBOX_W-1:0] num_bbox;
	logic [SET_W-1:0] set_idx;
	bbox_t [PE_NUM-1:0] set_bbox;
	// FSM to PEs
	logic [PE_NUM-1:0] start_fe;
	logic [PE_NUM-1:0] done_fe;
	logic [PE_NUM-1:0][FEAT_W-1:0] features;
	// FSM to registration
	logic set_done;
	logic [PE_NUM-1:0] active_mask;
	logic done_registration;
	// registration to result memory
	logic res_we;
	logic [BBOX_IDX_W-1:0] res_idx;
	logic [FEAT_W-1:0] res_data;
	logic [SUM_W-1:0] frame_sum;

	// --------------------
	// host registers
	// --------------------
	oflow_wb_regs u_regs (
		.clk         (clk),
		.reset_N     (reset_N),
		.wb_req      (wb_req),
		.wb_rsp      (wb_rsp),
		.frame_start (frame_start),
		.num_bbox    (num_bbox),
		.set_idx     (set_idx),
		.set_bbox    (set_bbox),
		.busy        (busy),
		.frame_done  (frame_done),
		.res_we      (res_we),
		.res_idx     (res_idx),
		.res_data    (res_data),
		.frame_sum   (frame_sum)
	);

	// --------------------
	// set control
	// --------------------
	oflow_fe_ctrl u_fe_ctrl (
		.clk               (clk),
		.reset_N           (reset_N),
		.frame_start       (frame_start),
		.num_bbox          (num_bbox),
		.set_idx           (set_idx),
		.start_fe          (start_fe),
		.done_fe           (done_fe),
		.set_done          (set_done),
		.active_mask       (active_mask),
		.done_registration (done_registration),
		.busy              (busy),
		.frame_done        (frame_done)
	);

	// one PE per box slot in the set
	for (genvar g = 0; g < PE_NUM; g++) begin : g_pe
		oflow_fe_pe u_pe (
			.clk     (clk),
			.reset_N (reset_N),
			.start   (start_fe[g]),
			.box     (set_bbox[g]),
			.done    (done_fe[g]),
			.feature (features[g])
		);
	end

	// --------------------
	// registration
	// --------------------
	oflow_registration u_reg (
		.clk               (clk),
		.reset_N           (reset_N),
		.frame_start       (frame_start),
		.set_done          (set_done),
		.active_mask       (active_mask),
		.set_idx           (set_idx),
		.features          (features),
		.res_we            (res_we),
		.res_idx           (res_idx),
		.res_data          (res_data),
		.frame_sum         (frame_sum),
		.done_registration (done_registration)
	);

endmodule

/* oflow_assert.sv */
// --------------------
// oflow core protocol assertions
// bus ack rules and PE start mask
// --------------------
`timescale 1ns/1ps

module oflow_assert import oflow_pkg::*; (
	input logic clk,
	input logic reset_N,
	input wb_req_t wb_req,
	input wb_rsp_t wb_rsp,
	input logic [PE_NUM-1:0] start_fe,
	input logic [NUM_BBOX_W-1:0] num_bbox,
	input logic [SET_W-1:0] set_idx
);

	// boxes from the current set to the end of the frame
	int boxes_left;

	assign boxes_left = int'(num_bbox) - int'(set_idx) * PE_NUM;

	// ack only answers a live strobe
	ack_needs_stb: assert property (@(posedge clk) disable iff (!reset_N)
		wb_rsp.ack |-> wb_req.stb)
		else $error("wishbone ack while stb is low");

	// single cycle ack, first cycle after a new strobe
	ack_one_cycle: assert property (@(posedge clk) disable iff (!reset_N)
		$rose(wb_req.stb) |=> wb_rsp.ack ##1 !wb_rsp.ack)
		else $error("wishbone ack not a single cycle after stb");

	// no PE started beyond the boxes left in the set
	// low bits only, as many as boxes remain, at most a full set
	start_in_mask: assert property (@(posedge clk) disable iff (!reset_N)
		start_fe != '0 |-> ((start_fe & (start_fe + 1'b1)) == '0)
			&& ($countones(start_fe) == ((boxes_left < PE_NUM) ? boxes_left : PE_NUM)))
		else $error("start_fe does not match the boxes left in the set");

endmodule

bind oflow_core_top oflow_assert u_assert (
	.clk      (clk),
	.reset_N  (reset_N),
	.wb_req   (wb_req),
	.wb_rsp   (wb_rsp),
	.start_fe (start_fe),
	.num_bbox (num_bbox),
	.set_idx  (set_idx)
);

/* oflow_tb.sv */
// --------------------
// oflow core testbench
// wishbone host, random frames, area model and checks
// --------------------
`timescale 1ns/1ps

module oflow_tb import oflow_pkg::*; ();

	localparam int CLK_PERIOD = 20;
	localparam int ACK_LIMIT = 16;
	localparam int POLL_LIMIT = 100;
	// --------------------
	// run length budget
	// --------------------
	localparam int NUM_FRAMES = 8;
	localparam int MAX_SETS = 8;
	localparam int SET_CYCLES = 20;
	// box writes, result reads, status polls, about 4 cycles each
	localparam int ACCESSES_PER_FRAME = 2 * MAX_BBOX + 64;
	localparam int WATCHDOG_CYCLES =
		NUM_FRAMES * (MAX_SETS * SET_CYCLES + 4 * ACCESSES_PER_FRAME) + 1000;

	logic clk;
	logic reset_N;
	wb_req_t wb_req;
	wb_rsp_t wb_rsp;

	integer seed;
	int errors;
	// host copy of the box memory and of the result memory
	logic [DAT_W-1:0] box_model [MAX_BBOX];
	logic [FEAT_W-1:0] res_model [MAX_BBOX];
	bit res_known [MAX_BBOX];
	logic [ADR_W-1:0] unmapped_adr [6] = '{8'h04, 8'h3F, 8'h60, 8'h7F, 8'hA0, 8'hFF};

	oflow_core_top uut (
		.clk     (clk),
		.reset_N (reset_N),
		.wb_req  (wb_req),
		.wb_rsp  (wb_rsp)
	);

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	// area of one box, straight from the fields
	function automatic logic [FEAT_W-1:0] area_of(input logic [DAT_W-1:0] word);
		bbox_t b;
		b = word;
		return FEAT_W'(b.w) * FEAT_W'(b.h);
	endfunction

	task automatic check_val(input string name, input logic [DAT_W-1:0] got,
			input logic [DAT_W-1:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s got=%h exp=%h at %0t", name, got, exp, $time);
			errors++;
		end
	endtask

	// --------------------
	// wishbone host
	// --------------------
	// request 1 ns after the edge, ack seen at the falling edge
	task automatic bus_xfer(input logic we, input logic [ADR_W-1:0] adr,
			input logic [DAT_W-1:0] wdat, output logic [DAT_W-1:0] rdat);
		int waited;
		waited = 0;
		rdat = '0;
		@(posedge clk);
		#1;
		wb_req.cyc = 1'b1;
		wb_req.stb = 1'b1;
		wb_req.we = we;
		wb_req.adr = adr;
		wb_req.dat = wdat;
		@(negedge clk);
		while (!wb_rsp.ack && waited < ACK_LIMIT) begin
			waited++;
			@(negedge clk);
		end
		if (wb_rsp.ack) begin
			rdat = wb_rsp.dat;
		end else begin
			$display("bus error: no ack from address %h at %0t", adr, $time);
			errors++;
		end
		// strobe held across the ack edge, released right after
		@(posedge clk);
		#1;
		wb_req = '0;
	endtask

	task automatic wb_write(input logic [ADR_W-1:0] adr, input logic [DAT_W-1:0] dat);
		logic [DAT_W-1:0] unused;
		bus_xfer(1'b1, adr, dat, unused);
	endtask

	task automatic wb_read(input logic [ADR_W-1:0] adr, output logic [DAT_W-1:0] dat);
		bus_xfer(1'b0, adr, '0, dat);
	endtask

	// --------------------
	// register access
	// --------------------
	task automatic check_registers();
		logic [DAT_W-1:0] rd;
		logic [DAT_W-1:0] cnt;
		cnt = DAT_W'($unsigned($random(seed)) % (MAX_BBOX + 1));
		wb_write(ADR_NUM_BBOX, cnt);
		wb_read(ADR_NUM_BBOX, rd);
		check_val("num_bbox", rd, cnt);
		for (int i = 0; i < MAX_BBOX; i++) begin
			box_model[i] = $random(seed);
			wb_write(ADR_BBOX_BASE + ADR_W'(i), box_model[i]);
		end
		for (int i = 0; i < MAX_BBOX; i++) begin
			wb_read(ADR_BBOX_BASE + ADR_W'(i), rd);
			check_val($sformatf("bbox[%0d]", i), rd, box_model[i]);
		end
		// holes in the map read back as zero
		foreach (unmapped_adr[i]) begin
			wb_read(unmapped_adr[i], rd);
			check_val($sformatf("unmapped %h", unmapped_adr[i]), rd, '0);
		end
	endtask

	// --------------------
	// one frame
	// --------------------
	task automatic run_frame(input int count);
		logic [DAT_W-1:0] rd;
		logic [SUM_W-1:0] sum_exp;
		int polls;
		sum_exp = '0;
		polls = 0;
		for (int i = 0; i < count; i++) begin
			box_model[i] = $random(seed);
			wb_write(ADR_BBOX_BASE + ADR_W'(i), box_model[i]);
		end
		wb_write(ADR_NUM_BBOX, DAT_W'(count));
		wb_write(ADR_CTRL, 32'h1);
		// busy up, done from last frame cleared
		wb_read(ADR_STATUS, rd);
		if (count != 0)
			check_val("status after start", rd, 32'h1);
		while (!rd[1] && polls < POLL_LIMIT) begin
			polls++;
			wb_read(ADR_STATUS, rd);
		end
		if (!rd[1]) begin
			$display("frame of %0d boxes never reported done", count);
			errors++;
		end
		check_val("status at end", rd, 32'h2);
		// slots past the count keep what the last frame left
		for (int i = 0; i < MAX_BBOX; i++) begin
			if (i < count) begin
				res_model[i] = area_of(box_model[i]);
				res_known[i] = 1'b1;
				sum_exp = sum_exp + SUM_W'(res_model[i]);
			end
			if (res_known[i]) begin
				wb_read(ADR_RES_BASE + ADR_W'(i), rd);
				check_val($sformatf("result[%0d]", i), rd, DAT_W'(res_model[i]));
			end
		end
		wb_read(ADR_FRAME_SUM, rd);
		check_val("frame_sum", rd, DAT_W'(sum_exp));
	endtask

	// --------------------
	// main sequence
	// --------------------
	initial begin
		logic [DAT_W-1:0] rnd;
		seed = 32'h1640e832;
		errors = 0;
		wb_req = '0;
		reset_N = 1'b0;
		repeat (2) @(posedge clk);
		#1;
		reset_N = 1'b1;

		check_registers();
		// empty frame first
		run_frame(0);
		// full sets only
		for (int f = 0; f < 2; f++) begin
			rnd = $random(seed);
			run_frame(4 * (int'(rnd[2:0]) + 1));
		end
		// partial last sets, back to back
		run_frame(31);
		run_frame(5);
		run_frame(1);
		// empty frame again, sum left by the last frame has to clear
		run_frame(0);
		run_frame(MAX_BBOX);

		$display("frames finished, errors: %0d", errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

	// hang guard
	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
		$display("Test FAILED");
		$finish;
	end

endmodule

/* tb.f */
oflow_pkg.sv
oflow_wb_regs.sv
oflow_fe_ctrl.sv
oflow_fe_pe.sv
oflow_registration.sv
oflow_core_top.sv
oflow_assert.sv
oflow_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = oflow_tb
FILELIST  = tb.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = Test FAILED
PASS_MSG  = Test OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
